// ==== common/lsu_cfg.svh ====
/*
 * Data memory configuration: RAM depth, acceptance wait-states and the
 * read latency of the bus slave.
 */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// depth in 32-bit words. It must be a power of two.
`define LSU_RAM_WORDS 256

// cycles of wait_req before a new request is accepted.
`define LSU_WAIT_STATES 2

// cycles from acceptance to the valid pulse. It is at least 1.
`define LSU_READ_LATENCY 2

`endif

// ==== common/lsu_pkg.sv ====
/*
 * Load/store unit types: the access format word and the request and
 * response structs shared by the core side, the bus master and the RAM.
 */
package lsu_pkg;

    // size codes of the format word.
    typedef enum logic [1:0] {
        SIZE_BYTE    = 2'd0,
        SIZE_HALF    = 2'd1,
        SIZE_WORD    = 2'd2,
        SIZE_ILLEGAL = 2'd3
    } access_size_t;

    // decoded view of funct3 for loads and stores.
    typedef struct packed {
        logic         is_unsigned;
        access_size_t size;
    } access_fields_t;

    // the core writes the raw code, the interface reads the fields.
    typedef union packed {
        logic [2:0]     code;
        access_fields_t fields;
    } access_format_t;

    // request as the core presents it, held until accepted.
    typedef struct packed {
        logic           read_enable;
        logic           write_enable;
        access_format_t format;
        logic [31:0]    address;
        logic [31:0]    write_data;
    } mem_request_t;

    // word-wide bus request with byte lanes already placed.
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] write_data;
        logic [3:0]  byte_enable;
        logic        read_enable;
        logic        write_enable;
    } bus_request_t;

    // slave response. valid is a single-cycle pulse per accepted read.
    typedef struct packed {
        logic [31:0] read_data;
        logic        wait_req;
        logic        valid;
    } bus_response_t;

endpackage

// ==== data_memory.f ====
+incdir+common
common/lsu_pkg.sv
design/data_memory_interface.sv
data_ram/data_ram.sv
design/data_memory_top.sv
tb/data_memory_sva.sv
tb/data_memory_tb.sv

// ==== data_ram/data_ram.sv ====
/*
 * Data RAM bus slave with byte write enables. Stalls each new request
 * for a fixed number of wait-states and returns reads after a fixed latency.
 */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module data_ram (
    input  logic                   clock,
    input  logic                   reset,
    input  lsu_pkg::bus_request_t  bus_request,
    output lsu_pkg::bus_response_t bus_response
);

    localparam int RAM_WORDS    = `LSU_RAM_WORDS;
    localparam int WAIT_STATES  = `LSU_WAIT_STATES;
    localparam int READ_LATENCY = `LSU_READ_LATENCY;
    localparam int INDEX_W      = $clog2(RAM_WORDS);
    localparam int WAIT_W       = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [31:0]        mem [RAM_WORDS];
    logic [INDEX_W-1:0] index;
    logic [WAIT_W-1:0]  wait_count;
    logic               active;
    logic               stall;
    logic               read_accept;
    logic               write_accept;

    // one valid bit and one data word per cycle of latency.
    logic [READ_LATENCY-1:0] valid_pipe;
    logic [31:0]             data_pipe [READ_LATENCY];

    // the depth is a power of two, so the low word-address bits wrap it.
    assign index = bus_request.address[INDEX_W+1:2];

    assign active       = bus_request.read_enable || bus_request.write_enable;
    assign stall        = active && (wait_count < WAIT_W'(WAIT_STATES));
    assign read_accept  = bus_request.read_enable && !stall;
    assign write_accept = bus_request.write_enable && !stall;

    // counts the stall cycles of the current request.
    // it restarts on acceptance and whenever the bus is idle.
    always_ff @(posedge clock) begin
        if (reset) begin
            wait_count <= '0;
        end else if (!active || !stall) begin
            wait_count <= '0;
        end else begin
            wait_count <= wait_count + 1'b1;
        end
    end

    // byte-lane write at the accepting edge.
    always_ff @(posedge clock) begin
        if (write_accept) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus_request.byte_enable[lane]) begin
                    mem[index][lane*8 +: 8] <= bus_request.write_data[lane*8 +: 8];
                end
            end
        end
    end

    // valid bits shift toward the output. The pipeline can carry several
    // reads back to back.
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= read_accept;
            for (int stage = 1; stage < READ_LATENCY; stage++) begin
                valid_pipe[stage] <= valid_pipe[stage-1];
            end
        end
    end

    // the word is captured when the read is accepted and then follows its valid bit.
    always_ff @(posedge clock) begin
        if (read_accept) begin
            data_pipe[0] <= mem[index];
        end
        for (int stage = 1; stage < READ_LATENCY; stage++) begin
            data_pipe[stage] <= data_pipe[stage-1];
        end
    end

    always_comb begin
        bus_response.read_data = data_pipe[READ_LATENCY-1];
        bus_response.wait_req  = stall;
        bus_response.valid     = valid_pipe[READ_LATENCY-1];
    end

endmodule

// ==== design/data_memory_interface.sv ====
/*
 * Data memory interface. Turns core loads and stores into byte-lane bus
 * requests and aligns and sign- or zero-extends the returned load data.
 */
`timescale 1ns/1ns

module data_memory_interface (
    input  logic                   clock,
    input  logic                   reset,
    input  lsu_pkg::mem_request_t  request,
    output logic [31:0]            read_data,
    output logic                   data_available,
    output logic                   request_successful,
    output lsu_pkg::bus_request_t  bus_request,
    input  lsu_pkg::bus_response_t bus_response
);

    logic [1:0]  byte_offset;
    logic [3:0]  byte_enable;
    logic [31:0] aligned_data;
    logic        sign_bit;
    logic        request_sent;
    logic        bus_read;
    logic        bus_write;

    assign byte_offset = request.address[1:0];

    // a read already in flight blocks the core's held enable until valid.
    assign bus_read  = request.read_enable && !request_sent;
    assign bus_write = request.write_enable && !request_sent;

    // lanes shifted past lane 3 fall off, so a crossing access is cut short.
    always_comb begin
        case (request.format.fields.size)
            lsu_pkg::SIZE_BYTE: byte_enable = 4'b0001 << byte_offset;
            lsu_pkg::SIZE_HALF: byte_enable = 4'b0011 << byte_offset;
            lsu_pkg::SIZE_WORD: byte_enable = 4'b1111 << byte_offset;
            default:            byte_enable = 4'b0000;
        endcase
    end

    always_comb begin
        bus_request.address      = request.address;
        bus_request.write_data   = request.write_data << {byte_offset, 3'b000};
        bus_request.byte_enable  = byte_enable;
        bus_request.read_enable  = bus_read;
        bus_request.write_enable = bus_write;
    end

    // bring the addressed byte or halfword down to bit 0.
    assign aligned_data = bus_response.read_data >> {byte_offset, 3'b000};

    always_comb begin
        sign_bit = 1'b0;
        case (request.format.fields.size)
            lsu_pkg::SIZE_BYTE: begin
                sign_bit  = !request.format.fields.is_unsigned && aligned_data[7];
                read_data = {{24{sign_bit}}, aligned_data[7:0]};
            end
            lsu_pkg::SIZE_HALF: begin
                sign_bit  = !request.format.fields.is_unsigned && aligned_data[15];
                read_data = {{16{sign_bit}}, aligned_data[15:0]};
            end
            lsu_pkg::SIZE_WORD: begin
                read_data = aligned_data;
            end
            default: begin
                read_data = 32'h0000_0000;
            end
        endcase
    end

    assign data_available     = bus_response.valid;
    assign request_successful = (bus_read || bus_write) && !bus_response.wait_req;

    // set when a read is accepted and cleared by its valid pulse.
    always_ff @(posedge clock) begin
        if (reset) begin
            request_sent <= 1'b0;
        end else if (bus_response.valid) begin
            request_sent <= 1'b0;
        end else if (bus_read && !bus_response.wait_req) begin
            request_sent <= 1'b1;
        end
    end

endmodule

// ==== design/data_memory_top.sv ====
/*
 * Data memory top level. The load/store interface acting as bus master,
 * joined to the data RAM slave.
 */
`timescale 1ns/1ns

module data_memory_top (
    input  logic                  clock,
    input  logic                  reset,
    input  lsu_pkg::mem_request_t request,
    output logic [31:0]           read_data,
    output logic                  data_available,
    output logic                  request_successful
);

    // bus between the interface and the RAM.
    lsu_pkg::bus_request_t  bus_request;
    lsu_pkg::bus_response_t bus_response;

    data_memory_interface interface_inst (
        .clock              (clock),
        .reset              (reset),
        .request            (request),
        .read_data          (read_data),
        .data_available     (data_available),
        .request_successful (request_successful),
        .bus_request        (bus_request),
        .bus_response       (bus_response)
    );

    // the RAM slave answers the bus requests of the interface.
    data_ram ram_inst (
        .clock        (clock),
        .reset        (reset),
        .bus_request  (bus_request),
        .bus_response (bus_response)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the data memory testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f data_memory.f \
    --top-module data_memory_tb \
    -Mdir obj_dir

./obj_dir/Vdata_memory_tb | tee sim.log

if grep -qx "Test passed" sim.log; then
    echo "simulation ok"
    exit 0
else
    echo "simulation reported errors, see sim.log"
    exit 1
fi

// ==== tb/data_memory_golden.txt ====
// columns: operation (1 store, 2 load, 3 held load), format code (funct3),
// byte address, then the store data or the expected load value.
// all values are hex, one access per line.
1 2 00000010 12345678
2 2 00000010 12345678
1 2 00000020 00000000
1 0 00000020 000000a1
1 0 00000021 000000b2
1 0 00000022 000000c3
1 0 00000023 000000d4
2 2 00000020 d4c3b2a1
1 2 00000030 11111111
1 1 00000030 0000beef
2 2 00000030 1111beef
1 1 00000032 5555cafe
2 2 00000030 cafebeef
1 0 00000031 ffffff00
2 2 00000030 cafe00ef
2 0 00000020 ffffffa1
2 4 00000020 000000a1
2 0 00000023 ffffffd4
2 4 00000023 000000d4
2 1 00000022 ffffd4c3
2 5 00000022 0000d4c3
2 1 00000020 ffffb2a1
2 5 00000020 0000b2a1
2 0 00000011 00000056
2 1 00000012 00001234
2 0 00000033 ffffffca
3 2 00000010 12345678
2 2 00000020 d4c3b2a1
2 3 00000010 00000000
2 7 00000020 00000000
1 3 00000010 deadbeef
2 2 00000010 12345678
1 2 00000404 a5a5a5a5
2 2 00000004 a5a5a5a5

// ==== tb/data_memory_sva.sv ====
/*
 * Bus protocol checks between the load/store interface and the data RAM,
 * bound into the top level.
 */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module data_memory_sva (
    input logic                   clock,
    input logic                   reset,
    input lsu_pkg::bus_request_t  bus_request,
    input lsu_pkg::bus_response_t bus_response
);

    logic read_accept;

    assign read_accept = bus_request.read_enable && !bus_response.wait_req;

    // a stalled request keeps every field until the slave accepts it.
    property hold_while_waiting;
        @(posedge clock) disable iff (reset)
        (bus_request.read_enable || bus_request.write_enable) && bus_response.wait_req
            |=> bus_request == $past(bus_request);
    endproperty

    // each valid pulse belongs to a read accepted a fixed number of cycles earlier.
    property valid_after_read;
        @(posedge clock) disable iff (reset)
        bus_response.valid |-> $past(read_accept, `LSU_READ_LATENCY);
    endproperty

    property single_direction;
        @(posedge clock) disable iff (reset)
        !(bus_request.read_enable && bus_request.write_enable);
    endproperty

    assert property (hold_while_waiting)
        else $error("bus request changed while wait_req was high");
    assert property (valid_after_read)
        else $error("valid without a read accepted at the read latency");
    assert property (single_direction)
        else $error("bus read_enable and write_enable high together");

endmodule

bind data_memory_top data_memory_sva protocol_checks (
    .clock        (clock),
    .reset        (reset),
    .bus_request  (bus_request),
    .bus_response (bus_response)
);

// ==== tb/data_memory_tb.sv ====
/*
 * Data memory testbench. Replays the golden access list against the top
 * level and checks load values and the acceptance and read-latency timing.
 */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module data_memory_tb;

    localparam int WAIT_STATES     = `LSU_WAIT_STATES;
    localparam int READ_LATENCY    = `LSU_READ_LATENCY;
    localparam int RESET_CYCLES    = 8;
    localparam int IDLE_CYCLES     = 6;
    localparam int CYCLES_PER_TEST = WAIT_STATES + READ_LATENCY + 6;
    localparam int MAX_TESTS       = 64;
    localparam int HEADER_LINES    = 3;

    localparam logic [31:0] OP_END       = 32'd0;
    localparam logic [31:0] OP_STORE     = 32'd1;
    localparam logic [31:0] OP_LOAD      = 32'd2;
    localparam logic [31:0] OP_HELD_LOAD = 32'd3;

    logic                  clock;
    logic                  reset;
    lsu_pkg::mem_request_t request;
    logic [31:0]           read_data;
    logic                  data_available;
    logic                  request_successful;

    // each access fills four words with its operation, format code, address and data.
    logic [31:0] golden [4*MAX_TESTS];
    int          test_count;
    int          pass_count;
    int          fail_count;
    logic        loaded;

    data_memory_top UUT (
        .clock              (clock),
        .reset              (reset),
        .request            (request),
        .read_data          (read_data),
        .data_available     (data_available),
        .request_successful (request_successful)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // the limit grows with the number of accesses in the golden file.
    initial begin
        int limit;
        wait (loaded);
        limit = RESET_CYCLES + IDLE_CYCLES + test_count * CYCLES_PER_TEST;
        repeat (limit) @(posedge clock);
        $display("TIMEOUT: the run did not finish within %0d clock cycles", limit);
        $display("Test failed");
        $finish;
    end

    function automatic string op_name(input logic [31:0] op);
        case (op)
            OP_STORE:     return "store";
            OP_LOAD:      return "load";
            OP_HELD_LOAD: return "held load";
            default:      return "unknown";
        endcase
    endfunction

    task automatic report_result(input string label, input bit ok);
        if (ok) begin
            pass_count++;
            $display("%s: ok", label);
        end else begin
            fail_count++;
            $display("%s: mismatch", label);
        end
    endtask

    // address, format and data stay in place so the load result can still be aligned.
    task automatic drop_enables();
        request.read_enable  = 1'b0;
        request.write_enable = 1'b0;
    endtask

    task automatic check_idle();
        int busy_cycles;
        busy_cycles = 0;
        repeat (IDLE_CYCLES) begin
            @(negedge clock);
            if (data_available || request_successful) begin
                busy_cycles++;
            end
        end
        if (busy_cycles != 0) begin
            $display("ERROR at %0t ns: idle bus, expected outputs low, got %0d busy cycles",
                     $time, busy_cycles);
        end
        report_result("idle after reset", busy_cycles == 0);
    endtask

    task automatic run_access(input int index);
        logic [31:0] op;
        logic [31:0] expected;
        logic [31:0] got;
        int          line;
        int          wait_cycles;
        int          latency;
        int          pulses;
        int          repeats;
        bit          is_load;
        bit          held;
        bit          seen;
        bit          ok;

        op       = golden[4*index];
        expected = golden[4*index+3];
        line     = HEADER_LINES + index + 1;
        is_load  = (op == OP_LOAD) || (op == OP_HELD_LOAD);
        held     = (op == OP_HELD_LOAD);
        got      = 32'h0;
        ok       = 1'b1;

        @(negedge clock);
        request.read_enable  = is_load;
        request.write_enable = !is_load;
        request.format.code  = golden[4*index+1][2:0];
        request.address      = golden[4*index+2];
        request.write_data   = is_load ? 32'h0 : expected;

        // request_successful is combinational, so it is looked at mid second half.
        wait_cycles = 0;
        #1;
        while (!request_successful && wait_cycles < WAIT_STATES + 4) begin
            @(negedge clock);
            #1;
            wait_cycles++;
        end

        if (!request_successful) begin
            $display("line %0d: the request was never accepted after %0d cycles",
                     line, wait_cycles);
            ok = 1'b0;
            @(negedge clock);
            drop_enables();
        end else begin
            if (wait_cycles != WAIT_STATES) begin
                $display("ERROR at %0t ns: line %0d acceptance delay, expected %0d, got %0d",
                         $time, line, WAIT_STATES, wait_cycles);
                ok = 1'b0;
            end
            if (is_load) begin
                latency = 0;
                seen    = 1'b0;
                repeats = 0;
                // a held read keeps its enable up until the data arrives.
                while (!seen && latency < READ_LATENCY + 4) begin
                    @(negedge clock);
                    latency++;
                    seen = data_available;
                    got  = read_data;
                    if (request_successful) begin
                        repeats++;
                    end
                    if (seen || !held) begin
                        drop_enables();
                    end
                end
                drop_enables();
                if (!seen) begin
                    $display("line %0d: the load never returned data within %0d cycles",
                             line, latency);
                    ok = 1'b0;
                end else begin
                    if (latency != READ_LATENCY) begin
                        $display("ERROR at %0t ns: line %0d read latency, expected %0d, got %0d",
                                 $time, line, READ_LATENCY, latency);
                        ok = 1'b0;
                    end
                    if (got !== expected) begin
                        $display("ERROR at %0t ns: line %0d load data, expected %08h, got %08h",
                                 $time, line, expected, got);
                        ok = 1'b0;
                    end
                end
                if (repeats != 0) begin
                    $display("line %0d: the read was accepted again while it was in flight",
                             line);
                    ok = 1'b0;
                end
            end else begin
                @(negedge clock);
                drop_enables();
            end
        end

        // one access gives at most one data_available pulse.
        pulses = 0;
        repeat (2) begin
            @(negedge clock);
            if (data_available) begin
                pulses++;
            end
        end
        if (pulses != 0) begin
            $display("ERROR at %0t ns: line %0d extra data pulses, expected 0, got %0d",
                     $time, line, pulses);
            ok = 1'b0;
        end

        report_result($sformatf("line %0d %s", line, op_name(op)), ok);
    endtask

    initial begin
        request    = '0;
        reset      = 1'b1;
        loaded     = 1'b0;
        pass_count = 0;
        fail_count = 0;
        test_count = 0;
        for (int i = 0; i < 4 * MAX_TESTS; i++) begin
            golden[i] = 32'h0;
        end
        $readmemh("tb/data_memory_golden.txt", golden);
        while (test_count < MAX_TESTS && golden[4*test_count] != OP_END) begin
            test_count++;
        end
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;

        check_idle();
        for (int t = 0; t < test_count; t++) begin
            run_access(t);
        end

        @(negedge clock);
        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
